//--- design/dac_sample_path.sv
/* Two-stage sample pipe per channel; the output stage flips the MSB to give
   offset binary. Both stages clear on either reset, so outputs start at 0. */
`timescale 1ns/1ps
`include "passthru_config.svh"

module dac_sample_path (
  input  logic                    ck933,
  input  logic                    rs,
  input  logic                    srst_i,
  input  passthru_pkg::dac_word_t dac0_data_i,
  input  passthru_pkg::dac_word_t dac1_data_i,
  input  passthru_pkg::dac_word_t dac2_data_i,
  output passthru_pkg::dac_word_t dac0_d_o,
  output passthru_pkg::dac_word_t dac1_d_o,
  output passthru_pkg::dac_word_t dac2_d_o
);

  import passthru_pkg::*;

  localparam int MSB = `DAC_WIDTH - 1;

  dac_word_t data_in [NUM_DAC];
  dac_word_t in_q    [NUM_DAC];     // Reclock stage
  dac_word_t out_q   [NUM_DAC];     // Output stage

  assign data_in[0] = dac0_data_i;
  assign data_in[1] = dac1_data_i;
  assign data_in[2] = dac2_data_i;

  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      for (int i = 0; i < NUM_DAC; i++) begin
        in_q[i]  <= '0;
        out_q[i] <= '0;
      end
    end else if (srst_i) begin
      for (int i = 0; i < NUM_DAC; i++) begin
        in_q[i]  <= '0;
        out_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < NUM_DAC; i++) begin
        in_q[i]  <= data_in[i];
        out_q[i] <= {~in_q[i][MSB], in_q[i][MSB-1:0]};  // Twos comp to offset
      end
    end
  end

  assign dac0_d_o = out_q[0];
  assign dac1_d_o = out_q[1];
  assign dac2_d_o = out_q[2];

endmodule

//--- design/dac_serial_ctrl.sv
/* 16-bit serial transfers, MSB first, sck idles low and the device samples on
   its rising edge. Bit 15 set makes a read: 8 bits out, 8 bits back. */
`timescale 1ns/1ps
`include "passthru_config.svh"

module dac_serial_ctrl (
  input  logic       ck933,
  input  logic       rs,
  input  logic       srst_i,
  host_bus_if.target bus_if,
  output logic       sck_o,
  output logic [2:0] ncs_o,
  output logic       sdio_o,
  output logic       sdio_oe_o,
  input  logic       sdio_i
);

  import passthru_pkg::*;

  localparam int               DIV_W    = $clog2(`SCK_DIV);
  localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`SCK_DIV - 1);
  localparam logic [DIV_W-1:0] DIV_HALF = DIV_W'(`SCK_DIV / 2);   // sck rises here

  dac_sel_t         ctrl_sel;     // CTRL register
  dac_sel_t         xfer_sel;     // Latched at start
  logic             busy;
  logic             rd_xfer;
  logic [DIV_W-1:0] div_cnt;
  logic [3:0]       bit_cnt;
  logic [15:0]      tx_sh;
  logic [7:0]       rdata_q;
  logic             ctrl_wr;
  logic             data_wr;
  logic             start;
  logic             bit_end;
  logic             resp_half;

  //**************************************************************************
  // Register writes
  //**************************************************************************

  assign ctrl_wr = bus_if.sel && bus_if.wr && (bus_if.addr == `DAC_CTRL_ADDR);
  assign data_wr = bus_if.sel && bus_if.wr && (bus_if.addr == `DAC_DATA_ADDR);
  assign start   = data_wr && !busy;    // Dropped while a transfer runs

  assign bit_end   = (div_cnt == DIV_LAST);
  assign resp_half = rd_xfer && bit_cnt[3];   // Bits 8 to 15 of a read

  //**************************************************************************
  // Transfer sequencer
  //**************************************************************************

  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      ctrl_sel <= SEL_NONE;
      xfer_sel <= SEL_NONE;
      busy     <= 1'b0;
      rd_xfer  <= 1'b0;
      div_cnt  <= '0;
      bit_cnt  <= '0;
      rdata_q  <= '0;
    end else if (srst_i) begin
      ctrl_sel <= SEL_NONE;
      xfer_sel <= SEL_NONE;
      busy     <= 1'b0;
      rd_xfer  <= 1'b0;
      div_cnt  <= '0;
      bit_cnt  <= '0;
      rdata_q  <= '0;
    end else begin
      if (ctrl_wr) begin
        ctrl_sel <= dac_sel_t'(bus_if.wdata[1:0]);
      end
      if (start) begin
        busy     <= 1'b1;
        rd_xfer  <= bus_if.wdata[15];
        xfer_sel <= ctrl_sel;
        div_cnt  <= '0;
        bit_cnt  <= '0;
      end else if (busy) begin
        div_cnt <= bit_end ? '0 : div_cnt + 1'b1;
        if (bit_end) begin
          bit_cnt <= bit_cnt + 1'b1;
          if (bit_cnt == 4'd15) begin
            busy <= 1'b0;                   // Last bit done
          end
        end
        // Capture one cycle into sck high, device changes on the falling edge
        if (resp_half && (div_cnt == DIV_HALF)) begin
          rdata_q <= {rdata_q[6:0], sdio_i};
        end
      end
    end
  end

  // Outgoing word, shifted at each bit boundary while sck is low
  always_ff @(posedge ck933) begin
    if (start) begin
      tx_sh <= bus_if.wdata;
    end else if (busy && bit_end) begin
      tx_sh <= {tx_sh[14:0], 1'b0};
    end
  end

  //**************************************************************************
  // Serial pins
  //**************************************************************************

  assign sck_o     = busy && (div_cnt >= DIV_HALF);
  assign sdio_o    = tx_sh[15];
  assign sdio_oe_o = busy && !resp_half;      // Turnaround after instruction byte

  always_comb begin
    for (int i = 0; i < NUM_DAC; i++) begin
      ncs_o[i] = !(busy && (xfer_sel == dac_sel_t'(i)));
    end
  end

  //**************************************************************************
  // Readback
  //**************************************************************************

  always_comb begin
    case (bus_if.addr)
      `DAC_CTRL_ADDR:  bus_if.rdata = {14'd0, ctrl_sel};
      `DAC_STAT_ADDR:  bus_if.rdata = {15'd0, busy};
      `DAC_RDATA_ADDR: bus_if.rdata = {8'd0, rdata_q};
      default:         bus_if.rdata = 16'd0;    // DATA is write only
    endcase
  end

endmodule

//--- design/host_bus_if.sv
/* Register bus from the top-level decode to one target.
   Reads are combinational; wr is a single-cycle strobe qualified by sel. */
`timescale 1ns/1ps

interface host_bus_if;

  logic        sel;     // Address inside this space, chip selected
  logic        wr;      // One-cycle write strobe
  logic [11:0] addr;
  logic [15:0] wdata;
  logic [15:0] rdata;   // From target, no clock

  modport host (
    output sel,
    output wr,
    output addr,
    output wdata,
    input  rdata
  );

  modport target (
    input  sel,
    input  wr,
    input  addr,
    input  wdata,
    output rdata
  );

endinterface

//--- design/misc_regs.sv
/* Any write to the reset offset starts a soft reset; the data is ignored.
   Version low half reads 0 and the high half returns the version number. */
`timescale 1ns/1ps
`include "passthru_config.svh"

module misc_regs (
  input  logic       ck933,
  input  logic       rs,
  host_bus_if.target bus_if,
  output logic       srst_o
);

  localparam int CNT_W = $clog2(`RESET_STRETCH + 1);

  logic [CNT_W-1:0] stretch_cnt;
  logic             rst_wr;

  //**************************************************************************
  // Soft reset and stretcher
  //**************************************************************************

  assign rst_wr = bus_if.sel && bus_if.wr && (bus_if.addr == `MISC_RESET_ADDR);

  // Held at full count during rs, so the pulse outlasts the pin reset
  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      stretch_cnt <= CNT_W'(`RESET_STRETCH);
    end else if (rst_wr) begin
      stretch_cnt <= CNT_W'(`RESET_STRETCH);    // Restart on every write
    end else if (stretch_cnt != '0) begin
      stretch_cnt <= stretch_cnt - 1'b1;
    end
  end

  // High for the loaded count, then drops with the counter at zero
  assign srst_o = (stretch_cnt != '0);

  //**************************************************************************
  // Readback
  //**************************************************************************

  always_comb begin
    case (bus_if.addr)
      `MISC_VER_LO_ADDR: bus_if.rdata = 16'h0000;
      `MISC_VER_HI_ADDR: bus_if.rdata = `VER_NUMBER;
      default:           bus_if.rdata = 16'h0000;   // Reset offset too
    endcase
  end

endmodule

//--- design/passthru_config.svh
/* Version, register map and timing constants shared by design and testbench.
   Addresses are 12-bit byte addresses; bits 11:8 pick the space. */
`ifndef PASSTHRU_CONFIG_SVH
`define PASSTHRU_CONFIG_SVH

`define VER_NUMBER        16'h00C4

// Space bases
`define MISC_BASE         12'h000
`define DAC_BASE          12'h100

// Misc space offsets
`define MISC_RESET_ADDR   12'h000
`define MISC_VER_LO_ADDR  12'h004
`define MISC_VER_HI_ADDR  12'h006

// DAC space offsets
`define DAC_CTRL_ADDR     12'h100
`define DAC_DATA_ADDR     12'h102
`define DAC_STAT_ADDR     12'h104
`define DAC_RDATA_ADDR    12'h106

`define DAC_WIDTH         14
`define RESET_STRETCH     6     // Cycles held after the cause ends
`define SCK_DIV           4     // ck933 cycles per serial bit, even

`endif

//--- design/passthru_pkg.sv
/* Types shared by the board-interface blocks.
   DAC select code 3 leaves every chip select high. */
`include "passthru_config.svh"

package passthru_pkg;

  //**************************************************************************
  // Host bus decode
  //**************************************************************************

  // Address space named by addr bits 11:8
  typedef enum logic [1:0] {
    MISC = 2'd0,
    DAC  = 2'd1,
    NONE = 2'd2
  } bus_space_e;

  //**************************************************************************
  // DAC types
  //**************************************************************************

  // One sample, two's complement on the way in
  typedef logic [`DAC_WIDTH-1:0] dac_word_t;

  // Serial port target, 0 to 2
  typedef logic [1:0] dac_sel_t;

  localparam dac_sel_t SEL_NONE = 2'd3;   // No chip selected

  // Number of DACs on the shared serial line
  localparam int NUM_DAC = 3;

endpackage

//--- design/passthru_top.sv
/* Host strobes are sampled on ck933; a write is one cycle with ncs_i and nwe_i
   low. Bidirectional pins are split into in, out and enable at this level. */
`timescale 1ns/1ps
`include "passthru_config.svh"

module passthru_top (
  input  logic                    ck933,
  input  logic                    rs,
  // Host bus
  input  logic                    ncs_i,
  input  logic                    nwe_i,
  input  logic                    nrd_i,
  input  logic [11:0]             addr_i,
  input  logic [15:0]             host_data_i,
  output logic [15:0]             host_data_o,
  output logic                    host_data_oe_o,
  // DAC serial port
  input  logic                    dac_sdio_i,
  output logic                    dac_sdio_o,
  output logic                    dac_sdio_oe_o,
  output logic                    dac0_ncs_o,
  output logic                    dac1_ncs_o,
  output logic                    dac2_ncs_o,
  output logic                    dac_sclk_o,
  output logic                    dac_rst_o,
  // DAC samples
  input  passthru_pkg::dac_word_t dac0_data_i,
  input  passthru_pkg::dac_word_t dac1_data_i,
  input  passthru_pkg::dac_word_t dac2_data_i,
  output passthru_pkg::dac_word_t dac0_d_o,
  output passthru_pkg::dac_word_t dac1_d_o,
  output passthru_pkg::dac_word_t dac2_d_o,
  // Pass-throughs
  input  logic                    bsync_lock_i,
  input  logic                    demod_lock_i,
  input  logic                    sdi_i,
  output logic                    bsync_nlock_o,
  output logic                    demod_nlock_o,
  output logic                    sdi_o
);

  import passthru_pkg::*;

  localparam logic [11:0] MISC_BASE_A = `MISC_BASE;
  localparam logic [11:0] DAC_BASE_A  = `DAC_BASE;

  bus_space_e space;
  logic [2:0] dac_ncs;
  logic       srst;

  host_bus_if misc_bus ();
  host_bus_if dac_bus ();

  //**************************************************************************
  // Address space decode
  //**************************************************************************

  always_comb begin
    if (addr_i[11:8] == MISC_BASE_A[11:8])     space = MISC;
    else if (addr_i[11:8] == DAC_BASE_A[11:8]) space = DAC;
    else                                       space = NONE;
  end

  assign misc_bus.sel   = !ncs_i && (space == MISC);
  assign misc_bus.wr    = misc_bus.sel && !nwe_i;
  assign misc_bus.addr  = addr_i;
  assign misc_bus.wdata = host_data_i;

  assign dac_bus.sel    = !ncs_i && (space == DAC);
  assign dac_bus.wr     = dac_bus.sel && !nwe_i;
  assign dac_bus.addr   = addr_i;
  assign dac_bus.wdata  = host_data_i;

  // Read mux, unmapped space reads 0
  always_comb begin
    case (space)
      MISC:    host_data_o = misc_bus.rdata;
      DAC:     host_data_o = dac_bus.rdata;
      default: host_data_o = 16'h0000;
    endcase
  end

  assign host_data_oe_o = !ncs_i && !nrd_i;

  //**************************************************************************
  // Blocks
  //**************************************************************************

  misc_regs i_misc (
    .ck933 (ck933),
    .rs    (rs),
    .bus_if(misc_bus.target),
    .srst_o(srst)
  );

  dac_serial_ctrl i_dac_ser (
    .ck933    (ck933),
    .rs       (rs),
    .srst_i   (srst),
    .bus_if   (dac_bus.target),
    .sck_o    (dac_sclk_o),
    .ncs_o    (dac_ncs),
    .sdio_o   (dac_sdio_o),
    .sdio_oe_o(dac_sdio_oe_o),
    .sdio_i   (dac_sdio_i)
  );

  dac_sample_path i_dac_path (
    .ck933      (ck933),
    .rs         (rs),
    .srst_i     (srst),
    .dac0_data_i(dac0_data_i),
    .dac1_data_i(dac1_data_i),
    .dac2_data_i(dac2_data_i),
    .dac0_d_o   (dac0_d_o),
    .dac1_d_o   (dac1_d_o),
    .dac2_d_o   (dac2_d_o)
  );

  assign dac0_ncs_o = dac_ncs[0];
  assign dac1_ncs_o = dac_ncs[1];
  assign dac2_ncs_o = dac_ncs[2];
  assign dac_rst_o  = srst;           // Same pulse as the internal reset

  // Lock inputs are already active low at the pins
  assign bsync_nlock_o = bsync_lock_i;
  assign demod_nlock_o = demod_lock_i;
  assign sdi_o         = sdi_i;

endmodule

//--- src.f
+incdir+design
design/passthru_pkg.sv
design/host_bus_if.sv
design/misc_regs.sv
design/dac_serial_ctrl.sv
design/dac_sample_path.sv
design/passthru_top.sv
tests/passthru_sva.sv
tests/passthru_tb.sv

//--- tests/passthru_sva.sv
/* Serial port and reset checks, bound into the DAC serial controller.
   The pulse width checks assume a single soft-reset write per pulse. */
`timescale 1ns/1ps
`include "passthru_config.svh"

module passthru_sva (
  input logic       ck933,
  input logic       rs,
  input logic       srst_i,
  input logic       busy_i,
  input logic [2:0] ncs_i,
  input logic       sdio_oe_i
);

  // Chip select falls only when all were high
  a_one_ncs: assert property (@(posedge ck933) disable iff (rs)
    |(~ncs_i & $past(ncs_i)) |-> ($past(ncs_i) == 3'b111))
    else $error("chip select moved from one DAC to another");

  // Turned-around line stays with the DAC to the end
  a_oe_turn: assert property (@(posedge ck933) disable iff (rs)
    busy_i && !sdio_oe_i |=> !sdio_oe_i)
    else $error("sdio output enable rose again inside a transfer");

  // Soft reset pulse from its first high sample
  a_soft_rst: assert property (@(posedge ck933) disable iff (rs)
    $rose(srst_i) |-> srst_i [*`RESET_STRETCH] ##1 !srst_i)
    else $error("soft reset pulse width wrong");

  a_pin_rst: assert property (@(posedge ck933)
    $fell(rs) |-> srst_i [*`RESET_STRETCH] ##1 !srst_i)
    else $error("reset stretch after pin reset wrong");

endmodule

bind dac_serial_ctrl passthru_sva i_sva (
  .ck933    (ck933),
  .rs       (rs),
  .srst_i   (srst_i),
  .busy_i   (busy),
  .ncs_i    (ncs_o),
  .sdio_oe_i(sdio_oe_o)
);

//--- tests/passthru_tb.sv
/* Random register, serial and sample traffic on the board-interface top.
   Inputs change on the falling clock edge; the DAC slave answers on sck. */
`timescale 1ns/1ps
`include "passthru_config.svh"

module passthru_tb;

  localparam int TIMEOUT = 400;     // Loop passes per wait
  localparam logic [`DAC_WIDTH-1:0] MSB_MASK = 1 << (`DAC_WIDTH - 1);

  logic ck933 = 1'b0;
  logic rs, ncs, nwe, nrd, sdio_in, bsync_lock, demod_lock, sdi;
  logic [11:0] addr;
  logic [15:0] host_wdata;
  logic [2:0][`DAC_WIDTH-1:0] din;
  wire  [15:0] host_rdata;
  wire  host_oe, sdio_out, sdio_oe, sclk, dac_rst, bsync_nlock, demod_nlock, sdo;
  wire  [2:0] dac_ncs;
  wire  [2:0][`DAC_WIDTH-1:0] dout;

  integer seed;
  int     err_cnt;
  int     to_cnt;
  int     w;
  logic [2:0] pt_cnt;

  // DAC slave model state
  int          slv_bits;
  int          slv_xfers;
  logic [15:0] slv_word;
  logic        slv_read;
  logic [7:0]  slv_resp;
  logic [2:0]  slv_ncs;

  passthru_top i_dut (
    .ck933(ck933), .rs(rs),
    .ncs_i(ncs), .nwe_i(nwe), .nrd_i(nrd), .addr_i(addr),
    .host_data_i(host_wdata), .host_data_o(host_rdata), .host_data_oe_o(host_oe),
    .dac_sdio_i(sdio_in), .dac_sdio_o(sdio_out), .dac_sdio_oe_o(sdio_oe),
    .dac0_ncs_o(dac_ncs[0]), .dac1_ncs_o(dac_ncs[1]), .dac2_ncs_o(dac_ncs[2]),
    .dac_sclk_o(sclk), .dac_rst_o(dac_rst),
    .dac0_data_i(din[0]), .dac1_data_i(din[1]), .dac2_data_i(din[2]),
    .dac0_d_o(dout[0]), .dac1_d_o(dout[1]), .dac2_d_o(dout[2]),
    .bsync_lock_i(bsync_lock), .demod_lock_i(demod_lock), .sdi_i(sdi),
    .bsync_nlock_o(bsync_nlock), .demod_nlock_o(demod_nlock), .sdi_o(sdo)
  );

  always #5 ck933 = ~ck933;

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      err_cnt++;
      $display("Error at %0t: %s, got 0x%0h, expected 0x%0h", $time, what, got, exp);
    end
  endtask

  //**************************************************************************
  // Host bus and DAC slave
  //**************************************************************************

  task automatic host_write(input logic [11:0] a, input logic [15:0] d);
    @(negedge ck933);
    ncs = 1'b0;
    nwe = 1'b0;
    addr = a;
    host_wdata = d;
    @(negedge ck933);
    ncs = 1'b1;
    nwe = 1'b1;
  endtask

  task automatic host_read(input logic [11:0] a, output logic [15:0] d);
    @(negedge ck933);
    ncs = 1'b0;
    nrd = 1'b0;
    addr = a;
    #1;
    check_eq(host_oe, 1'b1, "data enable during read");
    d = host_rdata;
    @(negedge ck933);
    ncs = 1'b1;
    nrd = 1'b1;
  endtask

  always @(negedge dac_ncs[0] or negedge dac_ncs[1] or negedge dac_ncs[2]) begin
    slv_bits = 0;                   // New transfer
    slv_xfers++;
    sdio_in = 1'b0;
  end

  always @(posedge sclk) begin
    slv_ncs = dac_ncs;
    if (slv_read && slv_bits >= 8) begin
      check_eq(sdio_oe, 1'b0, "sdio enable in response half");
      slv_word = {slv_word[14:0], slv_resp[15 - slv_bits]};
    end else begin
      check_eq(sdio_oe, 1'b1, "sdio enable in instruction half");
      slv_word = {slv_word[14:0], sdio_out};
    end
    if (slv_bits == 0) slv_read = sdio_out;   // Read flag leads the word
    slv_bits++;
  end

  // Device side changes the line on the falling sck edge
  always @(negedge sclk) begin
    if (slv_read && slv_bits >= 8 && slv_bits < 16) sdio_in = slv_resp[15 - slv_bits];
  end

  always @(negedge ck933) begin
    pt_cnt = pt_cnt + 3'd1;
    bsync_lock = pt_cnt[0];
    demod_lock = pt_cnt[1];
    sdi = pt_cnt[2];
  end

  always @(posedge ck933) begin
    check_eq(bsync_nlock, bsync_lock, "bsync lock pass-through");
    check_eq(demod_nlock, demod_lock, "demod lock pass-through");
    check_eq(sdo, sdi, "sdi pass-through");
  end

  //**************************************************************************
  // Test steps
  //**************************************************************************

  // Counts falling edges with dac_rst_o high, samples must stay cleared
  task automatic wait_rst_end(output int width);
    width = 0;
    while (dac_rst === 1'b1 && width < TIMEOUT) begin
      if (width > 0) begin
        for (int c = 0; c < 3; c++) check_eq(dout[c], 0, "sample output in reset");
      end
      @(negedge ck933);
      width++;
    end
    if (dac_rst !== 1'b0) begin
      to_cnt++;
      $display("Timeout: the DAC reset pin never went low");
    end
  endtask

  task automatic reg_read_test(input int n);
    logic [15:0] d;
    logic [11:0] a;
    logic [1:0]  r;
    host_read(`MISC_VER_LO_ADDR, d);
    check_eq(d, 16'h0000, "version low half");
    host_read(`MISC_VER_HI_ADDR, d);
    check_eq(d, `VER_NUMBER, "version high half");
    for (int k = 0; k < n; k++) begin
      a = $random(seed);
      if (a[11:8] == 4'h1) a[11] = 1'b1;      // Stay off the live DAC registers
      r = $random(seed);
      @(negedge ck933);
      ncs = r[0];
      nrd = r[1];
      addr = a;
      #1;
      check_eq(host_oe, !r[0] && !r[1], "data enable");
      check_eq(host_rdata, (a == `MISC_VER_HI_ADDR) ? `VER_NUMBER : 16'h0, "unmapped read");
    end
    @(negedge ck933);
    ncs = 1'b1;
    nrd = 1'b1;
  endtask

  task automatic sample_test(input int n);
    logic [2:0][`DAC_WIDTH-1:0] h0;
    logic [2:0][`DAC_WIDTH-1:0] h1;
    logic [`DAC_WIDTH-1:0]      v;
    for (int k = 0; k < n; k++) begin
      @(negedge ck933);
      for (int c = 0; c < 3; c++) begin
        if (k >= 2) check_eq(dout[c], h1[c] ^ MSB_MASK, $sformatf("sample channel %0d", c));
        h1[c] = h0[c];
        v = $random(seed);
        din[c] = v;
        h0[c] = v;
      end
    end
  endtask

  // Extra DATA write lands while busy and must be dropped
  task automatic serial_xfer(input logic [1:0] sel, input logic [15:0] word, input logic extra);
    logic [15:0] d;
    logic [2:0]  exp_ncs;
    int          xfers0;
    int          n;
    slv_resp = $random(seed);
    xfers0 = slv_xfers;
    exp_ncs = ~(3'b001 << sel);
    host_write(`DAC_CTRL_ADDR, {14'd0, sel});
    host_write(`DAC_DATA_ADDR, word);
    if (extra) host_write(`DAC_DATA_ADDR, ~word);
    host_read(`DAC_STAT_ADDR, d);
    check_eq(d[0], 1'b1, "busy after start");
    n = 0;
    while (d[0] === 1'b1 && n < TIMEOUT) begin
      host_read(`DAC_STAT_ADDR, d);
      n++;
    end
    if (d[0] !== 1'b0) begin
      to_cnt++;
      $display("Timeout: serial transfer to DAC %0d never finished", sel);
    end else begin
      check_eq(slv_xfers - xfers0, 1, "transfers seen by DAC");
      check_eq(slv_bits, 16, "bits per transfer");
      check_eq(slv_word, word[15] ? {word[15:8], slv_resp} : word, "word at DAC");
      check_eq(slv_ncs, exp_ncs, "chip selects");
      if (word[15]) begin
        host_read(`DAC_RDATA_ADDR, d);
        check_eq(d, slv_resp, "read back byte");
      end
    end
  endtask

  task automatic soft_reset_test();
    logic [15:0] d;
    int          width;
    host_write(`DAC_CTRL_ADDR, 16'd1);
    host_write(`DAC_DATA_ADDR, $random(seed));   // Cut short by the reset
    host_write(`MISC_RESET_ADDR, $random(seed));
    check_eq(dac_rst, 1'b1, "reset pin after soft reset write");
    wait_rst_end(width);
    check_eq(width, `RESET_STRETCH, "soft reset width");
    check_eq(dac_ncs, 3'b111, "chip selects after soft reset");
    check_eq(sclk, 1'b0, "sck after soft reset");
    check_eq(sdio_oe, 1'b0, "sdio enable after soft reset");
    host_read(`DAC_STAT_ADDR, d);
    check_eq(d, 16'd0, "status after soft reset");
  endtask

  initial begin
    seed = 66;
    err_cnt = 0;
    to_cnt = 0;
    pt_cnt = '0;
    rs = 1'b1;
    ncs = 1'b1;
    nwe = 1'b1;
    nrd = 1'b1;
    addr = '0;
    host_wdata = '0;
    din = '0;
    sdio_in = 1'b0;
    bsync_lock = 1'b0;
    demod_lock = 1'b0;
    sdi = 1'b0;
    slv_bits = 0;
    slv_xfers = 0;
    slv_word = '0;
    slv_read = 1'b0;
    slv_resp = '0;
    slv_ncs = 3'b111;
    repeat (5) @(negedge ck933);
    rs = 1'b0;
    wait_rst_end(w);
    check_eq(w, `RESET_STRETCH, "reset stretch after pin reset");
    if (to_cnt == 0) begin
      reg_read_test(60);
      sample_test(80);
      for (int i = 0; i < 6; i++) begin
        serial_xfer(2'({$random(seed)} % 3), {1'b0, 15'($random(seed))}, 1'b0);
      end
      for (int i = 0; i < 4; i++) begin
        serial_xfer(2'({$random(seed)} % 3), {1'b1, 15'($random(seed))}, 1'b0);
      end
      serial_xfer(2'({$random(seed)} % 3), {1'b0, 15'($random(seed))}, 1'b1);
      soft_reset_test();
    end
    $display("Checks done: %0d errors, %0d timeouts", err_cnt, to_cnt);
    if (err_cnt == 0 && to_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule
